//--- compile.f
+incdir+bench
src/atc_msg_pkg.sv
src/atc_field_pkg.sv
src/atc_fifo.sv
src/aircraft_id_pool.sv
src/runway_locks.sv
src/tower_controller.sv
src/reply_sender.sv
src/atc_top.sv
bench/atc_tb.sv

//--- bench/atc_tests.svh
// Directed tests for the tower top level
// Reset values, ID pool, clearances, runway release, divert and say-again

// Outputs straight after reset
task automatic test_reset_values();
  check_flag("in_ack", in_ack, 1'b0);
  check_flag("reply_req", reply_req, 1'b0);
  check_busy("runway_busy", runway_busy, 2'b00);
endtask

// Sixteen IDs in order, then the pool is exhausted
task automatic test_id_allocation();
  apply_reset();
  assign_ids(atc_msg_pkg::NUM_IDS);
  send_msg(make_msg('0, atc_msg_pkg::ID_PLEASE, 2'd0));
  expect_reply(make_msg('0, atc_msg_pkg::ID_PLEASE, atc_msg_pkg::ACTION_ID_FULL));
endtask

// Take-offs fill runway 0, then runway 1, then the third plane waits
task automatic test_takeoff_clearance();
  apply_reset();
  assign_ids(8);
  send_msg(make_msg(4'd0, atc_msg_pkg::REQUEST, 2'b00));
  expect_reply(make_msg(4'd0, atc_msg_pkg::HOLD, 2'd0));
  expect_reply(make_msg(4'd0, atc_msg_pkg::CLEAR, 2'd0));
  check_busy("runway_busy", runway_busy, 2'b01);

  send_msg(make_msg(4'd1, atc_msg_pkg::REQUEST, 2'b00));
  expect_reply(make_msg(4'd1, atc_msg_pkg::HOLD, 2'd0));
  expect_reply(make_msg(4'd1, atc_msg_pkg::CLEAR, 2'd1));
  check_busy("runway_busy", runway_busy, 2'b11);

  // No runway left, so this one stays queued
  send_msg(make_msg(4'd2, atc_msg_pkg::REQUEST, 2'b00));
  expect_reply(make_msg(4'd2, atc_msg_pkg::HOLD, 2'd0));
  check_busy("runway_busy", runway_busy, 2'b11);
endtask

// Only the owner may free runway 0, then plane 2 is cleared onto it
task automatic test_runway_release();
  send_msg(make_msg(4'd3, atc_msg_pkg::DECLARE, 2'd0));
  // Watched every cycle, since a wrong unlock would be refilled by plane 2 at once
  for (int i = 0; i < 4; i++) begin
    check_busy("runway_busy", runway_busy, 2'b11);
    wait_cycles(1);
  end

  send_msg(make_msg(4'd0, atc_msg_pkg::DECLARE, 2'd0));
  expect_reply(make_msg(4'd2, atc_msg_pkg::CLEAR, 2'd0));
  check_busy("runway_busy", runway_busy, 2'b11);
endtask

// Landing queue fills up, the fifth plane is diverted and loses its ID
task automatic test_landing_divert();
  apply_reset();
  assign_ids(8);
  send_msg(make_msg(4'd0, atc_msg_pkg::REQUEST, 2'b00));
  expect_reply(make_msg(4'd0, atc_msg_pkg::HOLD, 2'd0));
  expect_reply(make_msg(4'd0, atc_msg_pkg::CLEAR, 2'd0));
  send_msg(make_msg(4'd1, atc_msg_pkg::REQUEST, 2'b00));
  expect_reply(make_msg(4'd1, atc_msg_pkg::HOLD, 2'd0));
  expect_reply(make_msg(4'd1, atc_msg_pkg::CLEAR, 2'd1));
  check_busy("runway_busy", runway_busy, 2'b11);

  for (int i = 2; i < 6; i++) begin
    send_msg(make_msg(atc_msg_pkg::id_t'(i), atc_msg_pkg::REQUEST, 2'b10));
    expect_reply(make_msg(atc_msg_pkg::id_t'(i), atc_msg_pkg::HOLD, 2'd0));
  end
  send_msg(make_msg(4'd6, atc_msg_pkg::REQUEST, 2'b10));
  expect_reply(make_msg(4'd6, atc_msg_pkg::DIVERT, 2'd0));

  // ID 6 is now the lowest free one
  send_msg(make_msg('0, atc_msg_pkg::ID_PLEASE, 2'd0));
  expect_reply(make_msg(4'd6, atc_msg_pkg::ID_PLEASE, 2'd0));
endtask

// Unsupported types are echoed back, unknown planes get nothing
task automatic test_say_again();
  apply_reset();
  send_msg(make_msg(4'd5, atc_msg_pkg::EMERGENCY, 2'd1));
  expect_reply(make_msg(4'd5, atc_msg_pkg::SAY_AGAIN, 2'd0));
  send_msg(make_msg(4'd9, atc_msg_pkg::CLEAR, 2'd2));
  expect_reply(make_msg(4'd9, atc_msg_pkg::SAY_AGAIN, 2'd0));

  send_msg(make_msg(4'd12, atc_msg_pkg::REQUEST, 2'b10));
  send_msg(make_msg('0, atc_msg_pkg::ID_PLEASE, 2'd0));
  expect_reply(make_msg(4'd0, atc_msg_pkg::ID_PLEASE, 2'd0));
endtask

//--- bench/atc_tb.sv
// Testbench for the airfield tower top level
// Clock, reset, message source and reply sink, compare tasks and watchdog

`timescale 1ns/10ps

module atc_tb;

  localparam real PERIOD          = 4.0;
  localparam int  NUM_TESTS       = 6;
  localparam int  CYCLES_PER_TEST = 200;

  logic                 clock;
  logic                 reset;
  logic                 in_req;
  atc_msg_pkg::msg_t    in_msg;
  logic                 in_ack;
  logic                 reply_req;
  atc_msg_pkg::msg_t    reply_msg;
  logic                 reply_ack;
  atc_field_pkg::busy_t runway_busy;
  integer               seed;

  atc_top dut_i (
    .clock(clock), .reset(reset),
    .in_req(in_req), .in_msg(in_msg), .in_ack(in_ack),
    .reply_req(reply_req), .reply_msg(reply_msg), .reply_ack(reply_ack),
    .runway_busy(runway_busy)
  );

  always #(PERIOD / 2) clock = ~clock;

  //////////////////////////////////////////////////////////////////////////
  // Reporting and compare tasks
  //////////////////////////////////////////////////////////////////////////

  task automatic stop_with_error(input string reason);
    $display("%s", reason);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_msg(input string name, input atc_msg_pkg::msg_t actual,
                           input atc_msg_pkg::msg_t expected);
    if (actual !== expected) begin
      stop_with_error($sformatf("mismatch %s: got 0x%h, expected 0x%h",
                                name, actual, expected));
    end
  endtask

  task automatic check_busy(input string name, input atc_field_pkg::busy_t actual,
                            input atc_field_pkg::busy_t expected);
    if (actual !== expected) begin
      stop_with_error($sformatf("mismatch %s: got 0x%h, expected 0x%h",
                                name, actual, expected));
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      stop_with_error($sformatf("mismatch %s: got 0x%h, expected 0x%h",
                                name, actual, expected));
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Stimulus helpers that return 1 ns after a rising edge
  //////////////////////////////////////////////////////////////////////////

  function automatic atc_msg_pkg::msg_t make_msg(input atc_msg_pkg::id_t id,
                                                 input atc_msg_pkg::msg_type_t kind,
                                                 input logic [1:0] action);
    atc_msg_pkg::msg_t m;
    m.plane_id   = id;
    m.msg_type   = kind;
    m.msg_action = action;
    return m;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clock);
    #1;
  endtask

  task automatic apply_reset();
    @(posedge clock);
    #1;
    reset     = 1'b1;
    in_req    = 1'b0;
    reply_ack = 1'b0;
    wait_cycles(3);
    reset = 1'b0;
  endtask

  // Source side of the input four-phase handshake
  task automatic send_msg(input atc_msg_pkg::msg_t msg);
    in_msg = msg;
    in_req = 1'b1;
    while (!in_ack) wait_cycles(1);
    in_req = 1'b0;
    while (in_ack) wait_cycles(1);
  endtask

  // Sink side of the reply port, with a random acknowledge delay
  task automatic get_reply(output atc_msg_pkg::msg_t msg);
    int delay;
    while (!reply_req) wait_cycles(1);
    msg   = reply_msg;
    delay = $unsigned($random(seed)) % 4;
    repeat (delay) wait_cycles(1);
    reply_ack = 1'b1;
    while (reply_req) wait_cycles(1);
    reply_ack = 1'b0;
  endtask

  task automatic expect_reply(input atc_msg_pkg::msg_t expected);
    atc_msg_pkg::msg_t got;
    get_reply(got);
    check_msg("reply_msg", got, expected);
  endtask

  // Hands out IDs 0..n-1 on a pool that starts empty
  task automatic assign_ids(input int n);
    for (int i = 0; i < n; i++) begin
      send_msg(make_msg('0, atc_msg_pkg::ID_PLEASE, 2'd0));
      expect_reply(make_msg(atc_msg_pkg::id_t'(i), atc_msg_pkg::ID_PLEASE, 2'd0));
    end
  endtask

  `include "atc_tests.svh"

  //////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////////

  initial begin
    clock     = 1'b0;
    reset     = 1'b1;
    in_req    = 1'b0;
    in_msg    = '0;
    reply_ack = 1'b0;
    seed      = 32'hec04;
    apply_reset();
    test_reset_values();
    test_id_allocation();
    test_takeoff_clearance();
    test_runway_release();
    test_landing_divert();
    test_say_again();
    $display("PASS: all tests");
    $finish;
  end

  initial begin
    #(PERIOD * CYCLES_PER_TEST * NUM_TESTS);
    stop_with_error("Error: watchdog expired before the tests finished");
  end

endmodule

//--- src/atc_top.sv
// Airfield tower top level
// Tower controller feeding the reply FIFO, drained by the reply sender

`timescale 1ns/10ps

module atc_top #(
  parameter int QUEUE_DEPTH = atc_field_pkg::DEFAULT_QUEUE_DEPTH,
  parameter int REPLY_DEPTH = atc_field_pkg::DEFAULT_REPLY_DEPTH
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 in_req,
  input  atc_msg_pkg::msg_t    in_msg,
  output logic                 in_ack,
  output logic                 reply_req,
  output atc_msg_pkg::msg_t    reply_msg,
  input  logic                 reply_ack,
  output atc_field_pkg::busy_t runway_busy
);

  atc_msg_pkg::msg_t push_data;
  atc_msg_pkg::msg_t fifo_head;
  logic              push;
  logic              pop;
  logic              fifo_full;
  logic              fifo_empty;

  tower_controller #(.QUEUE_DEPTH(QUEUE_DEPTH)) controller (
    .clock(clock), .reset(reset),
    .in_req(in_req), .in_msg(in_msg), .in_ack(in_ack),
    .reply_data(push_data), .reply_push(push), .reply_full(fifo_full),
    .runway_busy(runway_busy)
  );

  atc_fifo #(.item_t(atc_msg_pkg::msg_t), .DEPTH(REPLY_DEPTH)) reply_fifo (
    .clock(clock), .reset(reset),
    .push(push), .push_data(push_data), .pop(pop),
    .head(fifo_head), .full(fifo_full), .empty(fifo_empty)
  );

  reply_sender sender (
    .clock(clock), .reset(reset),
    .fifo_head(fifo_head), .fifo_empty(fifo_empty), .pop(pop),
    .reply_req(reply_req), .reply_msg(reply_msg), .reply_ack(reply_ack)
  );

endmodule

//--- src/reply_sender.sv
// Reply sender: drains the reply FIFO over a four-phase req/ack port

`timescale 1ns/10ps

module reply_sender (
  input  logic              clock,
  input  logic              reset,
  input  atc_msg_pkg::msg_t fifo_head,
  input  logic              fifo_empty,
  output logic              pop,
  output logic              reply_req,
  output atc_msg_pkg::msg_t reply_msg,
  input  logic              reply_ack
);

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    ACK_LOW
  } state_t;

  state_t state;

  assign reply_req = (state == REQ);
  // The FIFO entry is dropped once the sink has taken it
  assign pop = (state == REQ) && reply_ack;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (!fifo_empty) state <= REQ;
        REQ:     if (reply_ack) state <= ACK_LOW;
        ACK_LOW: if (!reply_ack) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Message stays stable for the whole request phase
  always_ff @(posedge clock) begin
    if ((state == IDLE) && !fifo_empty) reply_msg <= fifo_head;
  end

endmodule

//--- src/tower_controller.sv
// Tower controller: four-phase input port, message interpreter FSM,
// take-off and landing queues, ID pool, runway locks and reply builder

`timescale 1ns/10ps

module tower_controller #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 in_req,
  input  atc_msg_pkg::msg_t    in_msg,
  output logic                 in_ack,
  output atc_msg_pkg::msg_t    reply_data,
  output logic                 reply_push,
  input  logic                 reply_full,
  output atc_field_pkg::busy_t runway_busy
);

  typedef enum logic [1:0] {
    IDLE,
    DECODE,
    REPLY
  } state_t;

  state_t            state;
  state_t            next_state;
  atc_msg_pkg::msg_t cur_msg;
  atc_msg_pkg::msg_t reply_next;
  logic              load_reply;
  logic              accept;
  logic              land_first;
  logic              toggle_prio;
  logic              pick_landing;

  // Plane queues
  logic             takeoff_push, takeoff_pop, takeoff_full, takeoff_empty;
  logic             landing_push, landing_pop, landing_full, landing_empty;
  atc_msg_pkg::id_t takeoff_head, landing_head;

  // ID pool and runway locks
  logic                             take_id, release_id, pool_full;
  atc_msg_pkg::id_t                 free_id;
  logic [atc_msg_pkg::NUM_IDS-1:0] taken;
  logic                             lock, unlock, runway_sel, free_sel;
  atc_msg_pkg::id_t                 lock_owner;

  ////////////////////////////////////////////////////////////////////////////
  // Sub-blocks
  ////////////////////////////////////////////////////////////////////////////

  atc_fifo #(.item_t(atc_msg_pkg::id_t), .DEPTH(QUEUE_DEPTH)) takeoff_queue (
    .clock(clock), .reset(reset),
    .push(takeoff_push), .push_data(cur_msg.plane_id), .pop(takeoff_pop),
    .head(takeoff_head), .full(takeoff_full), .empty(takeoff_empty)
  );

  atc_fifo #(.item_t(atc_msg_pkg::id_t), .DEPTH(QUEUE_DEPTH)) landing_queue (
    .clock(clock), .reset(reset),
    .push(landing_push), .push_data(cur_msg.plane_id), .pop(landing_pop),
    .head(landing_head), .full(landing_full), .empty(landing_empty)
  );

  aircraft_id_pool id_pool (
    .clock(clock), .reset(reset),
    .release_id(release_id), .release_value(cur_msg.plane_id), .take_id(take_id),
    .free_id(free_id), .taken(taken), .full(pool_full)
  );

  runway_locks locks (
    .clock(clock), .reset(reset),
    .lock(lock), .unlock(unlock), .runway_sel(runway_sel),
    .lock_owner(lock_owner), .unlock_owner(cur_msg.plane_id), .busy(runway_busy)
  );

  // Lowest free runway
  assign free_sel = runway_busy[0];

  // Landing wins when only it has planes, or when it is its turn
  assign pick_landing = !landing_empty && (takeoff_empty || land_first);
  assign lock_owner   = pick_landing ? landing_head : takeoff_head;

  ////////////////////////////////////////////////////////////////////////////
  // Interpreter FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    next_state   = state;
    reply_next   = cur_msg;
    load_reply   = 1'b0;
    accept       = 1'b0;
    toggle_prio  = 1'b0;
    takeoff_push = 1'b0;
    takeoff_pop  = 1'b0;
    landing_push = 1'b0;
    landing_pop  = 1'b0;
    take_id      = 1'b0;
    release_id   = 1'b0;
    lock         = 1'b0;
    unlock       = 1'b0;
    runway_sel   = free_sel;
    reply_push   = 1'b0;

    case (state)
      IDLE: begin
        if (in_req && !in_ack) begin
          accept     = 1'b1;
          next_state = DECODE;
        end else if (!(&runway_busy) && !(takeoff_empty && landing_empty)) begin
          // Clear the next plane onto the lowest free runway
          landing_pop = pick_landing;
          takeoff_pop = !pick_landing;
          toggle_prio = !takeoff_empty && !landing_empty;
          lock        = 1'b1;
          load_reply  = 1'b1;
          reply_next  = '{plane_id: lock_owner, msg_type: atc_msg_pkg::CLEAR,
                          msg_action: {pick_landing, free_sel}};
          next_state  = REPLY;
        end
      end

      DECODE: begin
        next_state = IDLE;
        case (cur_msg.msg_type)
          atc_msg_pkg::ID_PLEASE: begin
            load_reply = 1'b1;
            next_state = REPLY;
            if (pool_full) begin
              reply_next = '{plane_id: '0, msg_type: atc_msg_pkg::ID_PLEASE,
                             msg_action: atc_msg_pkg::ACTION_ID_FULL};
            end else begin
              take_id    = 1'b1;
              reply_next = '{plane_id: free_id, msg_type: atc_msg_pkg::ID_PLEASE,
                             msg_action: 2'd0};
            end
          end

          atc_msg_pkg::REQUEST: begin
            // Unknown planes are ignored
            if (taken[cur_msg.plane_id]) begin
              load_reply = 1'b1;
              next_state = REPLY;
              reply_next.msg_action = 2'd0;
              if (cur_msg.msg_action[1] ? landing_full : takeoff_full) begin
                release_id          = 1'b1;
                reply_next.msg_type = atc_msg_pkg::DIVERT;
              end else begin
                landing_push        = cur_msg.msg_action[1];
                takeoff_push        = !cur_msg.msg_action[1];
                reply_next.msg_type = atc_msg_pkg::HOLD;
              end
            end
          end

          atc_msg_pkg::DECLARE: begin
            if (taken[cur_msg.plane_id]) begin
              release_id = 1'b1;
              unlock     = 1'b1;
              runway_sel = cur_msg.msg_action[0];
            end
          end

          default: begin
            load_reply = 1'b1;
            next_state = REPLY;
            reply_next = '{plane_id: cur_msg.plane_id, msg_type: atc_msg_pkg::SAY_AGAIN,
                           msg_action: 2'd0};
          end
        endcase
      end

      REPLY: begin
        // Hold here while the reply FIFO is full
        reply_push = !reply_full;
        if (!reply_full) next_state = IDLE;
      end

      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= IDLE;
      in_ack     <= 1'b0;
      land_first <= 1'b1;
    end else begin
      state <= next_state;
      if (accept) in_ack <= 1'b1;
      else if (!in_req) in_ack <= 1'b0;
      if (toggle_prio) land_first <= !land_first;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) cur_msg <= in_msg;
    if (load_reply) reply_data <= reply_next;
  end

endmodule

//--- src/runway_locks.sv
// Runway lock records and busy vector
// Unlock only takes effect for the plane that holds the runway

`timescale 1ns/10ps

module runway_locks (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 lock,
  input  logic                 unlock,
  input  logic                 runway_sel,
  input  atc_msg_pkg::id_t     lock_owner,
  input  atc_msg_pkg::id_t     unlock_owner,
  output atc_field_pkg::busy_t busy
);

  atc_field_pkg::runway_t [atc_field_pkg::NUM_RUNWAYS-1:0] runways;

  always_comb begin
    for (int i = 0; i < atc_field_pkg::NUM_RUNWAYS; i++) begin
      busy[i] = runways[i].active;
    end
  end

  // Lock writes owner and active bit together
  // Unlock clears the active bit for the owner only
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < atc_field_pkg::NUM_RUNWAYS; i++) begin
        runways[i].active <= 1'b0;
      end
    end else if (lock) begin
      runways[runway_sel].active <= 1'b1;
      runways[runway_sel].owner  <= lock_owner;
    end else if (unlock && (runways[runway_sel].owner == unlock_owner)) begin
      runways[runway_sel].active <= 1'b0;
    end
  end

endmodule

//--- src/aircraft_id_pool.sv
// Aircraft ID pool: taken vector, lowest-free search and claim/release

`timescale 1ns/10ps

module aircraft_id_pool (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             release_id,
  input  atc_msg_pkg::id_t                 release_value,
  input  logic                             take_id,
  output atc_msg_pkg::id_t                 free_id,
  output logic [atc_msg_pkg::NUM_IDS-1:0] taken,
  output logic                             full
);

  assign full = &taken;

  // Scan downwards so the lowest clear bit is the last one written
  always_comb begin
    free_id = '0;
    for (int i = atc_msg_pkg::NUM_IDS - 1; i >= 0; i--) begin
      if (!taken[i]) free_id = atc_msg_pkg::id_t'(i);
    end
  end

  // A release in the same cycle as a take is served first
  always_ff @(posedge clock) begin
    if (reset) begin
      taken <= '0;
    end else if (release_id) begin
      taken[release_value] <= 1'b0;
    end else if (take_id && !full) begin
      taken[free_id] <= 1'b1;
    end
  end

endmodule

//--- src/atc_fifo.sv
// First-in first-out queue with a type parameter for the stored item
// Circular buffer with an occupancy count and a combinational head

`timescale 1ns/10ps

module atc_fifo #(
  parameter type item_t = logic [7:0],
  parameter int  DEPTH  = 4
) (
  input  logic  clock,
  input  logic  reset,
  input  logic  push,
  input  item_t push_data,
  input  logic  pop,
  output item_t head,
  output logic  full,
  output logic  empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  item_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Wrap explicitly so any depth works, not only powers of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (count == CNT_W'(DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign head    = mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= next_ptr(wr_ptr);
      if (do_pop) rd_ptr <= next_ptr(rd_ptr);
      // Push and pop together leave the count alone
      if (do_push && !do_pop) count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

endmodule

//--- src/atc_field_pkg.sv
// Airfield description: runway count, runway lock record, default queue depths

package atc_field_pkg;

  localparam int NUM_RUNWAYS = 2;

  // Depths used by the top level unless overridden
  localparam int DEFAULT_QUEUE_DEPTH = 4;
  localparam int DEFAULT_REPLY_DEPTH = 4;

  // One lock record per runway
  typedef struct packed {
    atc_msg_pkg::id_t owner;
    logic             active;
  } runway_t;

  // One busy bit per runway with bit 0 for runway 0
  typedef logic [NUM_RUNWAYS-1:0] busy_t;

endpackage

//--- src/atc_msg_pkg.sv
// Message format shared by the input port, the reply FIFO and the reply port
// Plane ID type, message type codes and the ID pool size

package atc_msg_pkg;

  // Plane IDs
  localparam int ID_W = 4;
  localparam int NUM_IDS = 16;

  typedef logic [ID_W-1:0] id_t;

  // Action value that tells a plane no ID was available
  localparam logic [1:0] ACTION_ID_FULL = 2'd3;

  // Codes 0..3 arrive from aircraft, codes 4..7 go back out
  typedef enum logic [2:0] {
    REQUEST   = 3'd0,
    DECLARE   = 3'd1,
    EMERGENCY = 3'd2,
    ID_PLEASE = 3'd3,
    CLEAR     = 3'd4,
    HOLD      = 3'd5,
    SAY_AGAIN = 3'd6,
    DIVERT    = 3'd7
  } msg_type_t;

  // One 9-bit message with the plane ID in the top bits
  typedef struct packed {
    id_t       plane_id;
    msg_type_t msg_type;
    logic [1:0] msg_action;
  } msg_t;

endpackage
